// ==== all.f ====
+incdir+test
src/digit_pkg.sv
src/button_sync.sv
src/pixel_scanner.sv
src/stroke_mask_rom.sv
src/match_accum.sv
src/ratio_compare.sv
src/best_match_tree.sv
src/digit_classifier_top.sv
test/tb_digit_classifier.sv

// ==== Makefile ====
# Verilator build for the digit classifier.
# Any variable below can be overridden on the command line, e.g.
#   make sim LOG=run1.log BUILD_DIR=build

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_digit_classifier
RTL_TOP   ?= digit_classifier_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint lint_rtl build sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed, see $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ----------------------------------------------------------------------
// software model of the stroke masks and the scorer
// ----------------------------------------------------------------------

// segment s is 0..6 for a..g.
function automatic bit on_bar(input int s, input int x, input int y);
    bit across;
    bit left;
    bit right;
    bit upper;
    bit lower;
    across = (x >= 5) && (x <= 24);
    left   = (x >= 5) && (x <= 7);
    right  = (x >= 22) && (x <= 24);
    upper  = (y >= 2) && (y <= 15);
    lower  = (y >= 13) && (y <= 27);
    case (s)
        0: return across && (y >= 2) && (y <= 4);     // a.
        1: return right && upper;                     // b.
        2: return right && lower;                     // c.
        3: return across && (y >= 25) && (y <= 27);   // d.
        4: return left && lower;                      // e.
        5: return left && upper;                      // f.
        6: return across && (y >= 13) && (y <= 15);   // g.
        default: return 1'b0;
    endcase
endfunction

function automatic logic [num_pixels-1:0] build_mask(input int d);
    logic [num_pixels-1:0] img;
    img = '0;
    for (int y = 0; y < grid_h; y++) begin
        for (int x = 0; x < grid_w; x++) begin
            for (int s = 0; s < 7; s++) begin
                if (seg_codes[d][s] && on_bar(s, x, y)) begin
                    img[y * grid_w + x] = 1'b1;
                end
            end
        end
    end
    return img;
endfunction

// best ratio of hits to coverage, the lowest digit among equals.
function automatic int expected_digit(input logic [num_pixels-1:0] img);
    logic [num_pixels-1:0] mask;
    int                    hit [num_classes];
    int                    cov [num_classes];
    int                    best;
    for (int d = 0; d < num_classes; d++) begin
        mask   = build_mask(d);
        hit[d] = 0;
        cov[d] = 0;
        for (int p = 0; p < num_pixels; p++) begin
            if (img[p] && mask[p]) begin
                hit[d] += 2;
                cov[d] += 2;
            end else if (img[p] || mask[p]) begin
                cov[d] += 1;
            end
        end
    end
    best = 0;
    for (int d = 1; d < num_classes; d++) begin
        if (longint'(hit[d]) * longint'(cov[best]) > longint'(hit[best]) * longint'(cov[d])) begin
            best = d;
        end
    end
    return best;
endfunction

`endif

// ==== test/tb_digit_classifier.sv ====
`timescale 1ns/100ps

module tb_digit_classifier;

    import digit_pkg::*;

    `include "tb_ref_model.svh"

    localparam int max_rows      = 48;
    localparam int valid_timeout = 1000;
    localparam int busy_timeout  = 20;
    localparam int window_cycles = 2000;
    localparam int scan_window   = num_pixels + 2;   // one scan, done and valid.

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  button_n;
    logic [num_pixels-1:0] bitmap;
    logic                  busy;
    logic [class_w-1:0]    digit;
    logic                  digit_valid;

    int                    seed = 32'h6cc1_4889;
    int                    num_rows = 0;
    string                 row_name   [max_rows];
    int                    row_expect [max_rows];
    logic [num_pixels-1:0] row_image  [max_rows];

    digit_classifier_top i_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .button_n    (button_n),
        .bitmap      (bitmap),
        .busy        (busy),
        .digit       (digit),
        .digit_valid (digit_valid)
    );

    always #10 i_clk = ~i_clk;   // 20 ns period.

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // expect_in below zero means the reference scorer decides.
    task automatic add_row(input string name, input int base, input int flips,
                           input int expect_in);
        logic [num_pixels-1:0] img;
        int                    idx;
        if (base < 0) begin
            img = '0;
        end else begin
            img = build_mask(base);
        end
        for (int f = 0; f < flips; f++) begin
            idx      = {$random(seed)} % num_pixels;
            img[idx] = ~img[idx];
        end
        row_name[num_rows]   = name;
        row_image[num_rows]  = img;
        row_expect[num_rows] = (expect_in < 0) ? expected_digit(img) : expect_in;
        num_rows++;
    endtask

    task automatic press_button();
        @(posedge i_clk);
        button_n <= 1'b0;
        repeat (4) @(posedge i_clk);
        button_n <= 1'b1;
    endtask

    task automatic wait_for_valid(input string name);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < valid_timeout && !seen; c++) begin
            @(negedge i_clk);
            seen = digit_valid;
        end
        if (!seen) begin
            report_failure($sformatf("%s: no digit_valid within %0d cycles, scanner in %s",
                                     name, valid_timeout, i_dut.u_pixel_scanner.state.name()));
        end
    endtask

    task automatic wait_for_busy(input string name);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < busy_timeout && !seen; c++) begin
            @(negedge i_clk);
            seen = busy;
        end
        if (!seen) begin
            report_failure($sformatf("%s: busy never rose, scanner in %s",
                                     name, i_dut.u_pixel_scanner.state.name()));
        end
    endtask

    // press_at < 0 leaves the button as it is.
    task automatic count_pulses(input int press_at, input int cycles, output int count,
                                output int last_digit);
        count      = 0;
        last_digit = -1;
        for (int c = 0; c < cycles; c++) begin
            @(posedge i_clk);
            if (c == press_at) button_n <= 1'b0;
            if (press_at >= 0 && c == press_at + 4) button_n <= 1'b1;
            @(negedge i_clk);
            if (digit_valid) begin
                count++;
                last_digit = int'(digit);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int pulses;
        int got;
        i_rst_n  <= 1'b0;
        button_n <= 1'b1;
        bitmap   <= '0;

        for (int d = 0; d < num_classes; d++) add_row($sformatf("exact_%0d", d), d, 0, d);
        add_row("blank", -1, 0, 0);   // all ratios zero.
        for (int d = 0; d < num_classes; d++) begin
            add_row($sformatf("noisy5_%0d", d), d, 5, -1);
            add_row($sformatf("noisy20_%0d", d), d, 20, -1);
            add_row($sformatf("noisy60_%0d", d), d, 60, -1);
        end

        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        for (int c = 0; c < 20; c++) begin
            @(negedge i_clk);
            check_value("idle_valid", 0, int'(digit_valid));
            check_value("idle_busy", 0, int'(busy));
        end

        for (int r = 0; r < num_rows; r++) begin
            @(posedge i_clk);
            bitmap <= row_image[r];
            press_button();
            wait_for_valid(row_name[r]);
            check_value(row_name[r], row_expect[r], int'(digit));
        end

        // held button, one scan only.
        @(posedge i_clk);
        bitmap   <= build_mask(3);
        button_n <= 1'b0;
        count_pulses(-1, window_cycles, pulses, got);
        check_value("held_pulses", 1, pulses);
        check_value("held_digit", 3, got);
        @(posedge i_clk);
        button_n <= 1'b1;
        repeat (10) @(posedge i_clk);

        // second press lands while busy, a restarted scan would end past the window.
        bitmap <= build_mask(7);
        press_button();
        wait_for_busy("busy_press");
        count_pulses(100, scan_window, pulses, got);
        check_value("busy_pulses", 1, pulses);
        check_value("busy_digit", 7, got);
        check_value("busy_after", 0, int'(busy));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src/digit_classifier_top.sv ====
`timescale 1ns/100ps

module digit_classifier_top (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             button_n,
    input  logic [digit_pkg::num_pixels-1:0] bitmap,
    output logic                             busy,
    output logic [digit_pkg::class_w-1:0]    digit,
    output logic                             digit_valid
);

    import digit_pkg::*;

    logic                                start;
    logic                                start_ok;
    logic [coord_w-1:0]                  x;
    logic [coord_w-1:0]                  y;
    logic                                pixel_valid;
    logic                                scan_done;
    logic [pix_idx_w-1:0]                pix_idx;
    logic                                drawn;
    logic [num_classes-1:0]              mask_bits;
    logic [num_classes-1:0][score_w-1:0] hits;
    logic [num_classes-1:0][score_w-1:0] coverage;

    // raster order, row by row.
    assign pix_idx  = pix_idx_w'(y) * pix_idx_w'(grid_w) + pix_idx_w'(x);
    assign drawn    = bitmap[pix_idx];
    assign start_ok = start && !busy;   // keeps a late press off the counters.

    button_sync u_button_sync (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .button_n (button_n),
        .start    (start)
    );

    pixel_scanner u_pixel_scanner (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .start       (start),
        .x           (x),
        .y           (y),
        .pixel_valid (pixel_valid),
        .scan_done   (scan_done),
        .busy        (busy)
    );

    stroke_mask_rom u_stroke_mask_rom (
        .x         (x),
        .y         (y),
        .mask_bits (mask_bits)
    );

    match_accum u_match_accum (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .start       (start_ok),
        .pixel_valid (pixel_valid),
        .drawn       (drawn),
        .mask_bits   (mask_bits),
        .hits        (hits),
        .coverage    (coverage)
    );

    best_match_tree u_best_match_tree (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .scan_done   (scan_done),
        .hits        (hits),
        .coverage    (coverage),
        .digit       (digit),
        .digit_valid (digit_valid)
    );

endmodule

// ==== src/best_match_tree.sv ====
`timescale 1ns/100ps

module best_match_tree (
    input  logic                                                 i_clk,
    input  logic                                                 i_rst_n,
    input  logic                                                 scan_done,
    input  logic [digit_pkg::num_classes-1:0][digit_pkg::score_w-1:0] hits,
    input  logic [digit_pkg::num_classes-1:0][digit_pkg::score_w-1:0] coverage,
    output logic [digit_pkg::class_w-1:0]                        digit,
    output logic                                                 digit_valid
);

    import digit_pkg::*;

    logic [4:0][class_w-1:0] l1_idx;
    logic [4:0][score_w-1:0] l1_hit;
    logic [4:0][score_w-1:0] l1_cov;
    logic [1:0][class_w-1:0] l2_idx;
    logic [1:0][score_w-1:0] l2_hit;
    logic [1:0][score_w-1:0] l2_cov;
    logic [class_w-1:0]      l3_idx;
    logic [score_w-1:0]      l3_hit;
    logic [score_w-1:0]      l3_cov;
    logic [class_w-1:0]      best_idx;

    // ------------------------------------------------------------------
    // comparator tree, the lower digit is always on side a
    // ------------------------------------------------------------------
    for (genvar p = 0; p < 5; p++) begin : g_pair
        ratio_compare u_cmp (
            .idx_a   (class_w'(2 * p)),
            .idx_b   (class_w'(2 * p + 1)),
            .hit_a   (hits[2*p]),
            .hit_b   (hits[2*p+1]),
            .cov_a   (coverage[2*p]),
            .cov_b   (coverage[2*p+1]),
            .idx_won (l1_idx[p]),
            .hit_won (l1_hit[p]),
            .cov_won (l1_cov[p])
        );
    end

    // 0..3 against each other, 4..7 against each other.
    for (genvar q = 0; q < 2; q++) begin : g_quad
        ratio_compare u_cmp (
            .idx_a   (l1_idx[2*q]),
            .idx_b   (l1_idx[2*q+1]),
            .hit_a   (l1_hit[2*q]),
            .hit_b   (l1_hit[2*q+1]),
            .cov_a   (l1_cov[2*q]),
            .cov_b   (l1_cov[2*q+1]),
            .idx_won (l2_idx[q]),
            .hit_won (l2_hit[q]),
            .cov_won (l2_cov[q])
        );
    end

    ratio_compare u_cmp_oct (
        .idx_a   (l2_idx[0]),
        .idx_b   (l2_idx[1]),
        .hit_a   (l2_hit[0]),
        .hit_b   (l2_hit[1]),
        .cov_a   (l2_cov[0]),
        .cov_b   (l2_cov[1]),
        .idx_won (l3_idx),
        .hit_won (l3_hit),
        .cov_won (l3_cov)
    );

    ratio_compare u_cmp_final (
        .idx_a   (l3_idx),
        .idx_b   (l1_idx[4]),
        .hit_a   (l3_hit),
        .hit_b   (l1_hit[4]),
        .cov_a   (l3_cov),
        .cov_b   (l1_cov[4]),
        .idx_won (best_idx),
        .hit_won (),
        .cov_won ()
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            digit       <= '0;
            digit_valid <= 1'b0;
        end else begin
            if (scan_done) begin
                digit <= best_idx;   // counters are final during done.
            end
            digit_valid <= scan_done;
        end
    end

endmodule

// ==== src/ratio_compare.sv ====
`timescale 1ns/100ps

module ratio_compare (
    input  logic [digit_pkg::class_w-1:0] idx_a,
    input  logic [digit_pkg::class_w-1:0] idx_b,
    input  logic [digit_pkg::score_w-1:0] hit_a,
    input  logic [digit_pkg::score_w-1:0] hit_b,
    input  logic [digit_pkg::score_w-1:0] cov_a,
    input  logic [digit_pkg::score_w-1:0] cov_b,
    output logic [digit_pkg::class_w-1:0] idx_won,
    output logic [digit_pkg::score_w-1:0] hit_won,
    output logic [digit_pkg::score_w-1:0] cov_won
);

    import digit_pkg::*;

    logic [prod_w-1:0] prod_a;
    logic [prod_w-1:0] prod_b;
    logic              a_wins;

    // hit_a / cov_a >= hit_b / cov_b without a divider.
    assign prod_a = prod_w'(hit_a) * prod_w'(cov_b);
    assign prod_b = prod_w'(hit_b) * prod_w'(cov_a);
    assign a_wins = (prod_a >= prod_b);   // equal goes to a.

    assign idx_won = a_wins ? idx_a : idx_b;
    assign hit_won = a_wins ? hit_a : hit_b;
    assign cov_won = a_wins ? cov_a : cov_b;

endmodule

// ==== src/match_accum.sv ====
`timescale 1ns/100ps

module match_accum (
    input  logic                                                 i_clk,
    input  logic                                                 i_rst_n,
    input  logic                                                 start,
    input  logic                                                 pixel_valid,
    input  logic                                                 drawn,
    input  logic [digit_pkg::num_classes-1:0]                    mask_bits,
    output logic [digit_pkg::num_classes-1:0][digit_pkg::score_w-1:0] hits,
    output logic [digit_pkg::num_classes-1:0][digit_pkg::score_w-1:0] coverage
);

    import digit_pkg::*;

    // ------------------------------------------------------------------
    // one hit / coverage counter pair per digit
    // ------------------------------------------------------------------
    for (genvar d = 0; d < num_classes; d++) begin : g_class

        logic [score_w-1:0] hit_inc;
        logic [score_w-1:0] cov_inc;

        always_comb begin
            if (drawn && mask_bits[d]) begin
                hit_inc = score_w'(2);   // stroke on the mask.
                cov_inc = score_w'(2);
            end else if (drawn || mask_bits[d]) begin
                hit_inc = '0;            // stray ink or missed stroke.
                cov_inc = score_w'(1);
            end else begin
                hit_inc = '0;
                cov_inc = '0;
            end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                hits[d]     <= '0;
                coverage[d] <= '0;
            end else if (start) begin
                hits[d]     <= '0;
                coverage[d] <= '0;
            end else if (pixel_valid) begin
                hits[d]     <= hits[d] + hit_inc;
                coverage[d] <= coverage[d] + cov_inc;
            end
        end

    end

endmodule

// ==== src/stroke_mask_rom.sv ====
`timescale 1ns/100ps

module stroke_mask_rom (
    input  logic [digit_pkg::coord_w-1:0]     x,
    input  logic [digit_pkg::coord_w-1:0]     y,
    output logic [digit_pkg::num_classes-1:0] mask_bits
);

    import digit_pkg::*;

    int                  xi;
    int                  yi;
    logic                on_left;
    logic                on_right;
    logic                across;
    logic                upper;
    logic                lower;
    logic [num_segs-1:0] seg_hit;

    function automatic logic in_span(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    assign xi = int'(x);
    assign yi = int'(y);

    // column and row bands shared by several bars.
    assign on_left  = in_span(xi, col_left, col_left + stroke_w - 1);
    assign on_right = in_span(xi, col_right, col_right + stroke_w - 1);
    assign across   = in_span(xi, col_left, col_right + stroke_w - 1);
    assign upper    = in_span(yi, row_top, row_mid + stroke_w - 1);
    assign lower    = in_span(yi, row_mid, row_bot + stroke_w - 1);

    // ------------------------------------------------------------------
    // bar membership
    // ------------------------------------------------------------------
    always_comb begin
        seg_hit[seg_a] = across && in_span(yi, row_top, row_top + stroke_w - 1);
        seg_hit[seg_g] = across && in_span(yi, row_mid, row_mid + stroke_w - 1);
        seg_hit[seg_d] = across && in_span(yi, row_bot, row_bot + stroke_w - 1);
        seg_hit[seg_f] = on_left && upper;
        seg_hit[seg_b] = on_right && upper;
        seg_hit[seg_e] = on_left && lower;
        seg_hit[seg_c] = on_right && lower;
    end

    // a pixel is on a digit when any lit bar of that digit covers it.
    always_comb begin
        for (int d = 0; d < num_classes; d++) begin
            mask_bits[d] = |(seg_hit & seg_codes[d]);
        end
    end

endmodule

// ==== src/pixel_scanner.sv ====
`timescale 1ns/100ps

module pixel_scanner (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          start,
    output logic [digit_pkg::coord_w-1:0] x,
    output logic [digit_pkg::coord_w-1:0] y,
    output logic                          pixel_valid,
    output logic                          scan_done,
    output logic                          busy
);

    import digit_pkg::*;

    scan_state_t state;
    logic        last_col;
    logic        last_pix;

    assign last_col = (x == coord_w'(grid_w - 1));
    assign last_pix = last_col && (y == coord_w'(grid_h - 1));

    // ------------------------------------------------------------------
    // state machine and raster counters
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= st_idle;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin   // a press while busy never gets here.
                        state <= st_scan;
                        x     <= '0;
                        y     <= '0;
                    end
                end
                st_scan: begin
                    if (last_col) begin
                        x <= '0;
                        y <= last_pix ? '0 : y + 1'b1;
                    end else begin
                        x <= x + 1'b1;
                    end
                    if (last_pix) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    state <= st_idle;   // done lasts one cycle.
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign pixel_valid = (state == st_scan);
    assign scan_done   = (state == st_done);
    assign busy        = (state != st_idle);

endmodule

// ==== src/button_sync.sv ====
`timescale 1ns/100ps

module button_sync (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic button_n,
    output logic start
);

    logic sync_q1;
    logic sync_q2;
    logic sync_q3;   // previous value of the synchronized button.

    // two-flop synchronizer, idles at released.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
            sync_q3 <= 1'b1;
        end else begin
            sync_q1 <= button_n;
            sync_q2 <= sync_q1;
            sync_q3 <= sync_q2;
        end
    end

    // one pulse per falling edge, a held button gives no more.
    assign start = sync_q3 && !sync_q2;

endmodule

// ==== src/digit_pkg.sv ====
package digit_pkg;

    // ------------------------------------------------------------------
    // drawing grid
    // ------------------------------------------------------------------
    localparam int grid_w     = 30;
    localparam int grid_h     = 30;
    localparam int num_pixels = grid_w * grid_h;
    localparam int pix_idx_w  = $clog2(num_pixels);   // raster index width.
    localparam int coord_w    = 5;

    // ------------------------------------------------------------------
    // classes and scores
    // ------------------------------------------------------------------
    localparam int num_classes = 10;
    localparam int class_w     = 4;
    localparam int score_w     = 16;           // worst case is 1800.
    localparam int prod_w      = 2 * score_w;  // cross product width.

    // ------------------------------------------------------------------
    // seven-segment strokes
    // ------------------------------------------------------------------
    localparam int num_segs = 7;
    localparam int seg_a    = 0;
    localparam int seg_b    = 1;
    localparam int seg_c    = 2;
    localparam int seg_d    = 3;
    localparam int seg_e    = 4;
    localparam int seg_f    = 5;
    localparam int seg_g    = 6;

    // bit n of a code is segment a + n, so the literals read gfedcba.
    localparam logic [num_segs-1:0] seg_codes [num_classes] = '{
        7'h3F,  // 0
        7'h06,  // 1
        7'h5B,  // 2
        7'h4F,  // 3
        7'h66,  // 4
        7'h6D,  // 5
        7'h7D,  // 6
        7'h07,  // 7
        7'h7F,  // 8
        7'h6F   // 9
    };

    // each bar is stroke_w pixels thick, starting at the given row or column.
    localparam int stroke_w  = 3;
    localparam int col_left  = 5;    // bars f and e.
    localparam int col_right = 22;   // bars b and c.
    localparam int row_top   = 2;    // bar a.
    localparam int row_mid   = 13;   // bar g.
    localparam int row_bot   = 25;   // bar d.

    typedef enum logic [1:0] {
        st_idle,
        st_scan,
        st_done
    } scan_state_t;

endpackage
